// File: flist.f
hsk_pkg.sv
hsk_sync_if.sv
uart_retime.sv
hsk_front_end.sv
hsk_byte_counter.sv
hskbus_merge.sv
hsk_uart_router.sv
hsk_uart_top.sv
hsk_uart_properties.sv
tb_hsk_uart.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_hsk_uart -f flist.f -o tb_hsk_uart \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_hsk_uart > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation PASSED"

// File: tb_hsk_uart.sv
`timescale 1ns/1ns
`default_nettype none

module tb_hsk_uart;
    import hsk_pkg::*;

    localparam int BAUD         = BAUD_PERIOD_DEF;
    localparam int EDGE_TIMEOUT = 4 * BAUD;
    localparam int WATCH_CYCLES = (FRAME_BITS + 1) * BAUD;
    // Serial line ids, DUT inputs first
    localparam int L_DBG_RX  = 0;
    localparam int L_TRX     = 1;
    localparam int L_SURF_TX = 2;
    localparam int L_HSK_RX  = 3;
    localparam int L_SURF_RX = 4;
    localparam int L_HSK_TX  = 5;
    localparam int L_DBG_TX  = 6;
    localparam int L_F_TTX   = 7;
    // Where a routed output takes its level from
    localparam logic [1:0] SRC_HIGH = 2'd0;
    localparam logic [1:0] SRC_DBG  = 2'd1;
    localparam logic [1:0] SRC_TRX  = 2'd2;
    localparam logic [1:0] SRC_BUS  = 2'd3;

    logic init_clk, rst_n, sys_reset_b;
    logic dbg_rx, trx, tctrl_b, surf_tx, hsk_rx;
    logic hsk_local_en, crate_en_user, crate_en_hsk;
    logic dbg_tx, f_ttx, surf_rx, hsk_tx, crate_en;
    logic [BYTE_COUNT_W-1:0] rx_bytes;
    logic [BYTE_COUNT_W-1:0] exp_count;
    // Crate enable expected for the current phase
    logic                    exp_crate_en;
    logic [5:0]              route;
    logic                    check_en;
    int                      seed;

    hsk_uart_top hsk_uart_top_i (
        .init_clk        (init_clk),
        .rst_n_i         (rst_n),
        .sys_reset_b_i   (sys_reset_b),
        .dbg_rx_i        (dbg_rx),
        .trx_i           (trx),
        .tctrl_b_i       (tctrl_b),
        .surf_tx_i       (surf_tx),
        .hsk_rx_i        (hsk_rx),
        .hsk_local_en_i  (hsk_local_en),
        .crate_en_user_i (crate_en_user),
        .crate_en_hsk_i  (crate_en_hsk),
        .dbg_tx_o        (dbg_tx),
        .f_ttx_o         (f_ttx),
        .surf_rx_o       (surf_rx),
        .hsk_tx_o        (hsk_tx),
        .crate_en_o      (crate_en),
        .rx_bytes_o      (rx_bytes)
    );

    initial begin
        init_clk = 1'b0;
        forever #5 init_clk = ~init_clk;
    end

    //////////////////////////////////////////////////
    // Reference model and error handling
    //////////////////////////////////////////////////

    // Sources of {bus_tx, dbg_tx_o, f_ttx_o}
    function automatic logic [5:0] expect_route(input logic local_en, input logic ctrl_b);
        if (local_en) begin
            return {SRC_DBG, SRC_BUS, SRC_HIGH};
        end else if (ctrl_b) begin
            // TURF quiet, replies still go up
            return {SRC_HIGH, SRC_HIGH, SRC_BUS};
        end else begin
            return {SRC_TRX, SRC_HIGH, SRC_BUS};
        end
    endfunction

    task automatic halt_failed();
        $display("Test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
            halt_failed();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        halt_failed();
    endtask

    //////////////////////////////////////////////////
    // Serial line access
    //////////////////////////////////////////////////

    function automatic logic sample_line(input int line);
        case (line)
            L_SURF_RX: return surf_rx;
            L_HSK_TX:  return hsk_tx;
            L_DBG_TX:  return dbg_tx;
            default:   return f_ttx;
        endcase
    endfunction

    task automatic drive_line(input int line, input logic level);
        case (line)
            L_DBG_RX:  dbg_rx = level;
            L_TRX:     trx = level;
            L_SURF_TX: surf_tx = level;
            default:   hsk_rx = level;
        endcase
    endtask

    // One 8N1 frame, LSB first, each bit BAUD cycles long
    task automatic send_byte(input int line, input logic [7:0] data);
        logic [FRAME_BITS-1:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(posedge init_clk);
            #1;
            drive_line(line, frame[0]);
            frame = frame >> 1;
            repeat (BAUD - 1) @(posedge init_clk);
        end
    endtask

    task automatic decode_byte(input int line, output logic [7:0] data);
        int   waited;
        logic prev;
        waited = 0;
        prev   = 1'b1;
        data   = '0;
        @(negedge init_clk);
        // Falling edge of the start bit
        while (!(prev && !sample_line(line))) begin
            if (waited == EDGE_TIMEOUT) begin
                report_timeout($sformatf("a start bit on line %0d", line));
            end
            waited++;
            prev = sample_line(line);
            @(negedge init_clk);
        end
        repeat (BAUD / 2) @(negedge init_clk);
        check_value(32'(sample_line(line)), 32'd0, "start bit low at mid-bit");
        // Shift in from the top, LSB lands at bit 0
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD) @(negedge init_clk);
            data = {sample_line(line), data[7:1]};
        end
        repeat (BAUD) @(negedge init_clk);
        check_value(32'(sample_line(line)), 32'd1, "stop bit high at mid-bit");
    endtask

    task automatic watch_high(input int line, input string name);
        for (int i = 0; i < WATCH_CYCLES; i++) begin
            @(negedge init_clk);
            check_value(32'(sample_line(line)), 32'd1, {name, " stays high"});
        end
    endtask

    task automatic wait_count_change(input logic [BYTE_COUNT_W-1:0] old);
        int waited;
        waited = 0;
        while (rx_bytes == old) begin
            if (waited == 2 * BAUD) begin
                report_timeout("the reply byte count to move");
            end
            waited++;
            @(negedge init_clk);
        end
    endtask

    // Mode inputs change together, then synchronisers settle
    task automatic set_mode(input logic local_en, input logic ctrl_b,
                            input logic en_user, input logic en_hsk,
                            input logic exp_en);
        @(posedge init_clk);
        #1;
        hsk_local_en  = local_en;
        tctrl_b       = ctrl_b;
        crate_en_user = en_user;
        crate_en_hsk  = en_hsk;
        exp_crate_en  = exp_en;
        repeat (BAUD + SYNC_STAGES) @(posedge init_clk);
    endtask

    //////////////////////////////////////////////////
    // Traffic through the crate bus
    //////////////////////////////////////////////////

    // Random byte from whichever line owns the bus toward the crate
    task automatic forward_down();
        logic [7:0] data;
        logic [7:0] got_surf;
        logic [7:0] got_hsk;
        logic [5:0] r;
        data = 8'($random(seed));
        r    = expect_route(hsk_local_en, tctrl_b);
        if (r[5:4] == SRC_HIGH) begin
            // Nobody owns the bus, TURF traffic goes nowhere
            fork
                send_byte(L_TRX, data);
                watch_high(L_SURF_RX, "surf_rx_o");
                watch_high(L_HSK_TX, "hsk_tx_o");
            join
        end else begin
            fork
                send_byte((r[5:4] == SRC_DBG) ? L_DBG_RX : L_TRX, data);
                decode_byte(L_SURF_RX, got_surf);
                decode_byte(L_HSK_TX, got_hsk);
            join
            check_value(32'(got_surf), 32'(data), "byte broadcast on surf_rx_o");
            check_value(32'(got_hsk), 32'(data), "byte broadcast on hsk_tx_o");
        end
    endtask

    // Reply from the crate, routed up and counted
    task automatic forward_up(input int line);
        logic [7:0] data;
        logic [7:0] got;
        logic [5:0] r;
        int         out_line;
        data     = 8'($random(seed));
        r        = expect_route(hsk_local_en, tctrl_b);
        out_line = (r[3:2] == SRC_BUS) ? L_DBG_TX : L_F_TTX;
        fork
            send_byte(line, data);
            decode_byte(out_line, got);
        join
        check_value(32'(got), 32'(data), "reply byte");
        wait_count_change(exp_count);
        exp_count = exp_count + 1'b1;
        check_value(32'(rx_bytes), 32'(exp_count), "reply byte count");
    endtask

    // Idle levels of unrouted outputs and the crate enable, every cycle
    always @(negedge init_clk) begin
        if (check_en) begin
            route = expect_route(hsk_local_en, tctrl_b);
            if (route[3:2] == SRC_HIGH) begin
                check_value(32'(dbg_tx), 32'd1, "dbg_tx_o idle outside local mode");
            end
            if (route[1:0] == SRC_HIGH) begin
                check_value(32'(f_ttx), 32'd1, "f_ttx_o idle in local mode");
            end
            check_value(32'(crate_en), 32'(exp_crate_en), "crate enable");
        end
    end

    initial begin
        int waited;
        seed          = 32'hde1cf7bc;
        rst_n         = 1'b0;
        sys_reset_b   = 1'b1;
        dbg_rx        = 1'b1;
        trx           = 1'b1;
        tctrl_b       = 1'b1;
        surf_tx       = 1'b1;
        hsk_rx        = 1'b1;
        hsk_local_en  = 1'b1;
        crate_en_user = 1'b0;
        crate_en_hsk  = 1'b0;
        exp_crate_en  = 1'b0;
        check_en      = 1'b0;
        exp_count     = '0;
        repeat (10) @(posedge init_clk);
        #1;
        rst_n = 1'b1;

        // Out of reset, everything idle
        @(negedge init_clk);
        check_value(32'(dbg_tx), 32'd1, "dbg_tx_o after reset");
        check_value(32'(f_ttx), 32'd1, "f_ttx_o after reset");
        check_value(32'(surf_rx), 32'd1, "surf_rx_o after reset");
        check_value(32'(hsk_tx), 32'd1, "hsk_tx_o after reset");
        check_value(32'(rx_bytes), 32'd0, "byte count after reset");
        check_en = 1'b1;

        // Local mode, crate opened by the user bit
        set_mode(1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
        forward_down();
        forward_up(L_SURF_TX);

        // TURF mode, crate opened by housekeeping
        set_mode(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        forward_down();
        forward_up(L_HSK_RX);

        // TURF holds control high
        set_mode(1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
        forward_down();
        forward_up(L_SURF_TX);

        // Crate shut, nothing passes and nothing counts
        set_mode(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        fork
            send_byte(L_DBG_RX, 8'($random(seed)));
            watch_high(L_SURF_RX, "surf_rx_o with crate off");
            watch_high(L_HSK_TX, "hsk_tx_o with crate off");
        join
        set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        fork
            send_byte(L_SURF_TX, 8'($random(seed)));
            watch_high(L_F_TTX, "f_ttx_o with crate off");
        join
        check_value(32'(rx_bytes), 32'(exp_count), "byte count with crate off");

        // SYS_RESET_B pulse clears the count
        @(posedge init_clk);
        #1;
        sys_reset_b = 1'b0;
        repeat (4) @(posedge init_clk);
        #1;
        sys_reset_b = 1'b1;
        waited = 0;
        while (rx_bytes != '0) begin
            if (waited == 8 * SYNC_STAGES) begin
                report_timeout("the byte count to clear");
            end
            waited++;
            @(negedge init_clk);
        end
        exp_count = '0;
        set_mode(1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
        forward_up(L_SURF_TX);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: hsk_uart_properties.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_uart_properties (
    input logic init_clk,
    input logic rst_n_i,
    input logic hsk_local_en_i,
    input logic dbg_tx_i,
    input logic f_ttx_i,
    input logic surf_rx_i,
    input logic hsk_tx_i,
    input logic crate_en_i
);

    //////////////////////////////////////////////////
    // Idle levels of the serial outputs
    //////////////////////////////////////////////////

    // Every line out of the block idles high in reset
    reset_idle: assert property (@(posedge init_clk)
        !rst_n_i |-> (dbg_tx_i && f_ttx_i && surf_rx_i && hsk_tx_i))
        else $error("serial output low during reset");

    // Debug port owns the bus, TURF line parked
    local_turf_idle: assert property (@(posedge init_clk)
        hsk_local_en_i |-> f_ttx_i)
        else $error("f_ttx_o active in local mode");

    // TURF owns the bus, debug line parked
    turf_dbg_idle: assert property (@(posedge init_clk)
        !hsk_local_en_i |-> dbg_tx_i)
        else $error("dbg_tx_o active outside local mode");

    // Crate shut
    crate_off_idle: assert property (@(posedge init_clk)
        !crate_en_i |-> surf_rx_i)
        else $error("surf_rx_o active with the crate disabled");

endmodule

bind hsk_uart_top hsk_uart_properties u_properties (
    .init_clk       (init_clk),
    .rst_n_i        (rst_n_i),
    .hsk_local_en_i (hsk_local_en_i),
    .dbg_tx_i       (dbg_tx_o),
    .f_ttx_i        (f_ttx_o),
    .surf_rx_i      (surf_rx_o),
    .hsk_tx_i       (hsk_tx_o),
    .crate_en_i     (crate_en_o)
);

`default_nettype wire

// File: hsk_uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_uart_top #(
    parameter int BAUD_PERIOD  = hsk_pkg::BAUD_PERIOD_DEF,
    parameter int SAMPLE_POINT = hsk_pkg::SAMPLE_POINT_DEF
) (
    input  logic                             init_clk,
    input  logic                             rst_n_i,
    input  logic                             sys_reset_b_i,
    input  logic                             dbg_rx_i,
    input  logic                             trx_i,
    input  logic                             tctrl_b_i,
    input  logic                             surf_tx_i,
    input  logic                             hsk_rx_i,
    input  logic                             hsk_local_en_i,
    input  logic                             crate_en_user_i,
    input  logic                             crate_en_hsk_i,
    output logic                             dbg_tx_o,
    output logic                             f_ttx_o,
    output logic                             surf_rx_o,
    output logic                             hsk_tx_o,
    output logic                             crate_en_o,
    output logic [hsk_pkg::BYTE_COUNT_W-1:0] rx_bytes_o
);

    // Toward the crate, from the router
    logic bus_tx;
    // From the crate, merged replies
    logic bus_rx;
    logic surf_rx_retimed;
    logic crate_en;

    hsk_sync_if sync_if ();

    assign crate_en_o = crate_en;

    hsk_front_end #(
        .BAUD_PERIOD  (BAUD_PERIOD),
        .SAMPLE_POINT (SAMPLE_POINT)
    ) u_front_end (
        .init_clk          (init_clk),
        .rst_n_i           (rst_n_i),
        .sys_reset_b_i     (sys_reset_b_i),
        .dbg_rx_i          (dbg_rx_i),
        .trx_i             (trx_i),
        .tctrl_b_i         (tctrl_b_i),
        .surf_tx_i         (surf_tx_i),
        .crate_en_i        (crate_en),
        .sync_if           (sync_if.front),
        .surf_rx_retimed_o (surf_rx_retimed)
    );

    hskbus_merge #(
        .BAUD_PERIOD (BAUD_PERIOD)
    ) u_merge (
        .init_clk          (init_clk),
        .rst_n_i           (rst_n_i),
        .crate_en_user_i   (crate_en_user_i),
        .crate_en_hsk_i    (crate_en_hsk_i),
        .bus_tx_i          (bus_tx),
        .surf_rx_retimed_i (surf_rx_retimed),
        .hsk_rx_i          (hsk_rx_i),
        .sync_if           (sync_if.merge),
        .bus_rx_o          (bus_rx),
        .surf_rx_o         (surf_rx_o),
        .hsk_tx_o          (hsk_tx_o),
        .crate_en_o        (crate_en),
        .rx_bytes_o        (rx_bytes_o)
    );

    hsk_uart_router u_router (
        .hsk_local_en_i (hsk_local_en_i),
        .bus_rx_i       (bus_rx),
        .sync_if        (sync_if.router),
        .bus_tx_o       (bus_tx),
        .dbg_tx_o       (dbg_tx_o),
        .f_ttx_o        (f_ttx_o)
    );

endmodule

`default_nettype wire

// File: hsk_uart_router.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_uart_router (
    input  logic       hsk_local_en_i,
    input  logic       bus_rx_i,
    hsk_sync_if.router sync_if,
    output logic       bus_tx_o,
    output logic       dbg_tx_o,
    output logic       f_ttx_o
);
    import hsk_pkg::*;

    route_mode_e mode;

    // Local enable wins, otherwise the TURF control line decides
    always_comb begin
        if (hsk_local_en_i) begin
            mode = ROUTE_LOCAL;
        end else if (sync_if.tctrl_b) begin
            mode = ROUTE_IDLE;
        end else begin
            mode = ROUTE_TURF;
        end
    end

    // Unused directions idle high
    always_comb begin
        bus_tx_o = 1'b1;
        dbg_tx_o = 1'b1;
        f_ttx_o  = 1'b1;
        case (mode)
            ROUTE_LOCAL: begin
                // Debug port owns the crate bus
                bus_tx_o = sync_if.dbg_rx;
                dbg_tx_o = bus_rx_i;
            end
            ROUTE_TURF: begin
                bus_tx_o = sync_if.trx;
                f_ttx_o  = bus_rx_i;
            end
            ROUTE_IDLE: begin
                // TURF not talking, but replies still go back
                f_ttx_o = bus_rx_i;
            end
            default: begin
                bus_tx_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hskbus_merge.sv
`timescale 1ns/1ns
`default_nettype none

module hskbus_merge #(
    parameter int BAUD_PERIOD = hsk_pkg::BAUD_PERIOD_DEF
) (
    input  logic                             init_clk,
    input  logic                             rst_n_i,
    input  logic                             crate_en_user_i,
    input  logic                             crate_en_hsk_i,
    input  logic                             bus_tx_i,
    input  logic                             surf_rx_retimed_i,
    input  logic                             hsk_rx_i,
    hsk_sync_if.merge                        sync_if,
    output logic                             bus_rx_o,
    output logic                             surf_rx_o,
    output logic                             hsk_tx_o,
    output logic                             crate_en_o,
    output logic [hsk_pkg::BYTE_COUNT_W-1:0] rx_bytes_o
);

    // Either the user bit or housekeeping can open the crate bus
    assign crate_en_o = crate_en_user_i | crate_en_hsk_i;

    // Broadcast to SURFs and the local housekeeping processor
    // Idle high with the crate shut
    assign surf_rx_o = crate_en_o ? bus_tx_i : 1'b1;
    assign hsk_tx_o  = crate_en_o ? bus_tx_i : 1'b1;

    // Replies share the line like open drain, so wired-AND
    assign bus_rx_o = crate_en_o ? (surf_rx_retimed_i & hsk_rx_i) : 1'b1;

    // Count good reply bytes on the merged line
    hsk_byte_counter #(
        .BAUD_PERIOD (BAUD_PERIOD)
    ) u_byte_counter (
        .init_clk (init_clk),
        .rst_n_i  (rst_n_i),
        .clear_i  (sync_if.bus_rst),
        .rx_i     (bus_rx_o),
        .count_o  (rx_bytes_o)
    );

endmodule

`default_nettype wire

// File: hsk_byte_counter.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_byte_counter #(
    parameter int BAUD_PERIOD = hsk_pkg::BAUD_PERIOD_DEF
) (
    input  logic                             init_clk,
    input  logic                             rst_n_i,
    input  logic                             clear_i,
    input  logic                             rx_i,
    output logic [hsk_pkg::BYTE_COUNT_W-1:0] count_o
);
    import hsk_pkg::*;

    localparam int CYC_W = $clog2(BAUD_PERIOD);
    localparam int BIT_W = $clog2(FRAME_BITS);
    localparam logic [CYC_W-1:0] HALF_CYC  = CYC_W'(BAUD_PERIOD / 2 - 1);
    localparam logic [CYC_W-1:0] LAST_CYC  = CYC_W'(BAUD_PERIOD - 1);
    // Index of the last data bit
    localparam logic [BIT_W-1:0] LAST_DATA = BIT_W'(FRAME_BITS - 3);

    rx_state_e        state_q;
    logic [CYC_W-1:0] cyc_q;
    logic [BIT_W-1:0] bit_q;
    logic             rx_q;

    //////////////////////////////////////////////////
    // Frame check and byte count
    //////////////////////////////////////////////////

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            cyc_q   <= '0;
            bit_q   <= '0;
            rx_q    <= 1'b1;
            count_o <= '0;
        end else if (clear_i) begin
            // Bus reset from the TURF
            state_q <= RX_IDLE;
            cyc_q   <= '0;
            bit_q   <= '0;
            rx_q    <= 1'b1;
            count_o <= '0;
        end else begin
            rx_q  <= rx_i;
            cyc_q <= cyc_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cyc_q <= '0;
                    if (rx_q && !rx_i) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Middle of start bit, glitches fall back to idle
                    if (cyc_q == HALF_CYC) begin
                        cyc_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rx_i ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (cyc_q == LAST_CYC) begin
                        cyc_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == LAST_DATA) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (cyc_q == LAST_CYC) begin
                        // Only a high stop bit makes a good byte
                        if (rx_i) begin
                            count_o <= count_o + 1'b1;
                        end
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hsk_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_front_end #(
    parameter int BAUD_PERIOD  = hsk_pkg::BAUD_PERIOD_DEF,
    parameter int SAMPLE_POINT = hsk_pkg::SAMPLE_POINT_DEF
) (
    input  logic       init_clk,
    input  logic       rst_n_i,
    input  logic       sys_reset_b_i,
    input  logic       dbg_rx_i,
    input  logic       trx_i,
    input  logic       tctrl_b_i,
    input  logic       surf_tx_i,
    input  logic       crate_en_i,
    hsk_sync_if.front  sync_if,
    output logic       surf_rx_retimed_o
);
    import hsk_pkg::*;

    localparam int N_LINES = 4;

    // Bit order: 3 surf_tx, 2 tctrl_b, 1 trx, 0 dbg_rx
    logic [N_LINES-1:0]                  async_in;
    logic [SYNC_STAGES-1:0][N_LINES-1:0] sync_q;
    logic [N_LINES-1:0]                  sync_out;
    logic                                bus_rst_q;

    assign async_in = {surf_tx_i, tctrl_b_i, trx_i, dbg_rx_i};
    assign sync_out = sync_q[SYNC_STAGES-1];

    //////////////////////////////////////////////////
    // Synchronisers and system reset register
    //////////////////////////////////////////////////

    // All four lines idle high, so reset to ones
    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], async_in};
        end
    end

    // SYS_RESET_B is pulled up, so bus reset idles low
    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_rst_q <= 1'b0;
        end else begin
            bus_rst_q <= ~sys_reset_b_i;
        end
    end

    assign sync_if.dbg_rx  = sync_out[0];
    assign sync_if.trx     = sync_out[1];
    assign sync_if.tctrl_b = sync_out[2];
    assign sync_if.bus_rst = bus_rst_q;

    // Open-drain SURF line, cleaned up after the synchroniser
    uart_retime #(
        .BAUD_PERIOD  (BAUD_PERIOD),
        .SAMPLE_POINT (SAMPLE_POINT)
    ) u_retime (
        .init_clk     (init_clk),
        .rst_n_i      (rst_n_i),
        .enable_i     (crate_en_i),
        .rx_i         (sync_out[3]),
        .rx_retimed_o (surf_rx_retimed_o)
    );

endmodule

`default_nettype wire

// File: uart_retime.sv
`timescale 1ns/1ns
`default_nettype none

module uart_retime #(
    parameter int BAUD_PERIOD  = hsk_pkg::BAUD_PERIOD_DEF,
    parameter int SAMPLE_POINT = hsk_pkg::SAMPLE_POINT_DEF
) (
    input  logic init_clk,
    input  logic rst_n_i,
    input  logic enable_i,
    input  logic rx_i,
    output logic rx_retimed_o
);
    import hsk_pkg::*;

    localparam int CYC_W = $clog2(BAUD_PERIOD);
    localparam int BIT_W = $clog2(FRAME_BITS);
    localparam logic [CYC_W-1:0] SAMPLE_AT = CYC_W'(SAMPLE_POINT);
    localparam logic [CYC_W-1:0] LAST_CYC  = CYC_W'(BAUD_PERIOD - 1);
    localparam logic [BIT_W-1:0] STOP_BIT  = BIT_W'(FRAME_BITS - 1);

    retime_state_e    state_q;
    // Cycle within the current bit
    logic [CYC_W-1:0] cyc_q;
    // Bit index within the frame
    logic [BIT_W-1:0] bit_q;
    // Previous line level for the edge detect
    logic             rx_q;
    logic             fall;

    assign fall = rx_q & ~rx_i;

    //////////////////////////////////////////////////
    // Frame timing
    //////////////////////////////////////////////////

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= RT_IDLE;
            cyc_q        <= '0;
            bit_q        <= '0;
            rx_q         <= 1'b1;
            rx_retimed_o <= 1'b1;
        end else begin
            rx_q <= rx_i;
            if (!enable_i) begin
                // Crate off, drop any frame in flight
                state_q      <= RT_IDLE;
                rx_retimed_o <= 1'b1;
            end else begin
                case (state_q)
                    RT_IDLE: begin
                        rx_retimed_o <= 1'b1;
                        if (fall) begin
                            // Edge cycle counts as cycle 0 of the start bit
                            state_q <= RT_FRAME;
                            cyc_q   <= CYC_W'(1);
                            bit_q   <= '0;
                        end
                    end
                    RT_FRAME: begin
                        // Take the settled level and hold it
                        if (cyc_q == SAMPLE_AT) begin
                            rx_retimed_o <= rx_i;
                        end
                        if (cyc_q == LAST_CYC) begin
                            cyc_q <= '0;
                            if (bit_q == STOP_BIT) begin
                                // Stop bit period over, line idles high again
                                state_q      <= RT_IDLE;
                                rx_retimed_o <= 1'b1;
                            end else begin
                                bit_q <= bit_q + 1'b1;
                            end
                        end else begin
                            cyc_q <= cyc_q + 1'b1;
                        end
                    end
                    default: state_q <= RT_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hsk_sync_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hsk_sync_if;

    // Debug receive, synchronised
    logic dbg_rx;
    // TURF receive, synchronised
    logic trx;
    // TURF control, synchronised, low selects the serial path
    logic tctrl_b;
    // Bus reset from the registered SYS_RESET_B
    logic bus_rst;

    // Front end drives everything
    modport front (
        output dbg_rx,
        output trx,
        output tctrl_b,
        output bus_rst
    );

    // Router only needs the serial lines and the control
    modport router (
        input dbg_rx,
        input trx,
        input tctrl_b
    );

    // Merge only needs the bus reset
    modport merge (
        input bus_rst
    );

endinterface

`default_nettype wire

// File: hsk_pkg.sv
`default_nettype none

package hsk_pkg;

    //////////////////////////////////////////////////
    // Serial timing defaults
    //////////////////////////////////////////////////

    // Baud period in init_clk cycles
    localparam int BAUD_PERIOD_DEF = 160;
    // Retime sample offset inside one bit
    // Late in the bit so a slow open-drain rise has settled
    localparam int SAMPLE_POINT_DEF = 120;

    // Depth of the input synchronisers
    localparam int SYNC_STAGES = 2;

    // Start, 8 data, stop
    localparam int FRAME_BITS = 10;

    // Width of the reply byte counter, wraps
    localparam int BYTE_COUNT_W = 8;

    //////////////////////////////////////////////////
    // State and mode encodings
    //////////////////////////////////////////////////

    // SURF reply retimer
    typedef enum logic {
        RT_IDLE  = 1'b0,
        RT_FRAME = 1'b1
    } retime_state_e;

    // Reply frame receiver for the byte counter
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

    // Crate bus ownership
    // IDLE is TURF mode while the TURF holds its control line high
    typedef enum logic [1:0] {
        ROUTE_LOCAL = 2'd0,
        ROUTE_TURF  = 2'd1,
        ROUTE_IDLE  = 2'd2
    } route_mode_e;

endpackage

`default_nettype wire
